/* verilog/rt_geom_pkg.sv */
package rt_geom_pkg;

  localparam int COORD_W = 12;

  localparam int SCREEN_W = 1024;
  localparam int SCREEN_H = 768;

  typedef logic signed [COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  typedef struct packed {
    coord_t cx;
    coord_t cy;
    coord_t cz;
    coord_t r;
    coord_t pad0;                                      // Fills the word to cylinder size
    coord_t pad1;
  } sphere_t;

  typedef struct packed {
    coord_t cx;
    coord_t cz;
    coord_t r;
    coord_t y_lo;                                      // Upright along y, closed range
    coord_t y_hi;
    coord_t pad0;
  } cylinder_t;

  typedef union packed {
    sphere_t   sph;
    cylinder_t cyl;
  } obj_desc_t;

endpackage

/* verilog/rt_trace_pkg.sv */
package rt_trace_pkg;

  localparam int OBJ_IDX_W = 4;
  localparam int DEPTH_W = 13;

  typedef logic [OBJ_IDX_W-1:0] obj_idx_t;

  // Hit depth along z, larger is nearer to the viewer
  typedef logic signed [DEPTH_W-1:0] depth_t;

  localparam depth_t NO_HIT_DEPTH = {1'b1, {(DEPTH_W-1){1'b0}}};

  // Bit positions in select_objs
  localparam int SEL_SPHERE = 1;
  localparam int SEL_CYL = 0;

  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

endpackage

/* verilog/isqrt.sv */
`timescale 1ns/1ps

module isqrt (
  input  logic        aclk,
  input  logic        aresetn,
  input  logic        start,
  input  logic [23:0] radicand,
  output logic        done,
  output logic [11:0] root
);

  localparam int ISQRT_STEPS = 12;

  logic [23:0] rad_q;
  logic [13:0] rem_q;
  logic [11:0] root_q;
  logic [3:0]  step_q;
  logic        busy;

  logic [23:0] rad_in;
  logic [13:0] rem_in;
  logic [11:0] root_in;
  logic [13:0] rem_sh;
  logic [13:0] trial;
  logic        ge;

  // First step works straight from the input word
  always_comb begin
    rad_in  = start ? radicand : rad_q;
    rem_in  = start ? '0 : rem_q;
    root_in = start ? '0 : root_q;
    rem_sh  = {rem_in[11:0], rad_in[23:22]};         // Remainder stays below 2^12 before a step
    trial   = {root_in, 2'b01};
    ge      = rem_sh >= trial;
  end

  always_ff @(posedge aclk) begin
    if (aresetn) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      step_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy   <= 1'b1;
        step_q <= 4'd1;
      end else if (busy) begin
        step_q <= step_q + 4'd1;
        if (step_q == 4'(ISQRT_STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;                                // Last root bit lands with this edge
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (start || busy) begin
      rad_q  <= {rad_in[21:0], 2'b00};
      rem_q  <= ge ? rem_sh - trial : rem_sh;
      root_q <= {root_in[10:0], ge};
    end
  end

  assign root = root_q;

endmodule

/* verilog/ray_intersect.sv */
`timescale 1ns/1ps

module ray_intersect
  import rt_geom_pkg::*, rt_trace_pkg::*;
(
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      start,
  input  coord_t    px,
  input  coord_t    py,
  input  obj_desc_t obj,
  input  logic      is_cylinder,
  output logic      done,
  output logic      hit,
  output depth_t    depth
);

  coord_t             cx;
  coord_t             cz;
  coord_t             r;
  logic signed [12:0] dx;
  logic signed [12:0] dy;
  logic signed [26:0] dx_sq;
  logic signed [26:0] dy_sq;
  logic signed [26:0] r_sq;
  logic signed [26:0] disc;
  logic               y_out;

  logic [23:0]        rad_q;
  coord_t             cz_q;
  logic               neg_q;
  logic               y_out_q;
  logic               sqrt_start;
  logic               sqrt_done;
  logic [11:0]        sqrt_root;

  always_comb begin
    cx = obj.sph.cx;                                   // Center x sits in the same bits in both views
    if (is_cylinder) begin
      cz    = obj.cyl.cz;
      r     = obj.cyl.r;
      dy    = '0;                                      // Infinite along y inside its range
      y_out = (py < obj.cyl.y_lo) || (py > obj.cyl.y_hi);
    end else begin
      cz    = obj.sph.cz;
      r     = obj.sph.r;
      dy    = py - obj.sph.cy;
      y_out = 1'b0;
    end
    dx    = px - cx;
    dx_sq = dx * dx;
    dy_sq = dy * dy;
    r_sq  = r * r;
    disc  = r_sq - dx_sq - dy_sq;
  end

  always_ff @(posedge aclk) begin
    if (aresetn) begin
      sqrt_start <= 1'b0;
      done       <= 1'b0;
    end else begin
      sqrt_start <= start;
      done       <= sqrt_done;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      rad_q   <= disc[23:0];                           // A nonnegative disc is at most r^2
      cz_q    <= cz;
      neg_q   <= disc < 0;
      y_out_q <= y_out;
    end
    if (sqrt_done) begin
      depth <= depth_t'(cz_q) + depth_t'({1'b0, sqrt_root});
      hit   <= !neg_q && !y_out_q;
    end
  end

  isqrt i_isqrt (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .start    (sqrt_start),
    .radicand (rad_q),
    .done     (sqrt_done),
    .root     (sqrt_root)
  );

endmodule

/* verilog/hit_point.sv */
`timescale 1ns/1ps

module hit_point
  import rt_geom_pkg::*, rt_trace_pkg::*;
(
  input  coord_t    px,
  input  coord_t    py,
  input  depth_t    depth,
  input  obj_desc_t obj,
  input  logic      is_cylinder,
  output vec3_t     hit_pos,
  output vec3_t     hit_normal
);

  coord_t cx;
  coord_t cy;
  coord_t cz;
  coord_t z;

  always_comb begin
    z  = coord_t'(depth);                              // Scene keeps hits inside coordinate range
    cx = obj.sph.cx;                                   // Same bits in both views

    if (is_cylinder) begin
      cy = '0;
      cz = obj.cyl.cz;
    end else begin
      cy = obj.sph.cy;
      cz = obj.sph.cz;
    end

    hit_pos.x = px;
    hit_pos.y = py;
    hit_pos.z = z;

    // Unnormalized radial normal for both kinds
    hit_normal.x = px - cx;
    hit_normal.y = is_cylinder ? coord_t'(0) : py - cy;
    hit_normal.z = z - cz;
  end

endmodule

/* verilog/scene_store.sv */
`timescale 1ns/1ps

module scene_store
  import rt_geom_pkg::*, rt_trace_pkg::*;
#(
  parameter int NUM_CYL = 10
) (
  input  logic      aclk,
  input  logic      wr_en,
  input  obj_idx_t  wr_idx,
  input  obj_desc_t wr_data,
  input  obj_idx_t  rd_idx_a,
  input  obj_idx_t  rd_idx_b,
  output obj_desc_t rd_data_a,
  output obj_desc_t rd_data_b
);

  localparam int NUM_OBJ = NUM_CYL + 1;                // Cylinders first, sphere last

  obj_desc_t mem [NUM_OBJ];

  always_ff @(posedge aclk) begin
    if (wr_en && int'(wr_idx) < NUM_OBJ) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // Two asynchronous read ports for test and winner lookups
  assign rd_data_a = (int'(rd_idx_a) < NUM_OBJ) ? mem[rd_idx_a] : '0;
  assign rd_data_b = (int'(rd_idx_b) < NUM_OBJ) ? mem[rd_idx_b] : '0;

endmodule

/* verilog/check_objects.sv */
`timescale 1ns/1ps

module check_objects
  import rt_geom_pkg::*, rt_trace_pkg::*;
#(
  parameter int NUM_CYL = 10
) (
  input  logic      aclk,
  input  logic      aresetn,
  input  logic      ray_valid,
  output logic      ray_ready,
  input  hcount_t   ray_hcount,
  input  vcount_t   ray_vcount,
  input  logic [1:0] select_objs,
  output obj_idx_t  test_idx,
  output obj_idx_t  win_idx,
  input  obj_desc_t test_obj,
  input  obj_desc_t win_obj,
  output logic      result_valid,
  output vec3_t     hit_point,
  output vec3_t     normal,
  output logic      hit_sphere,
  output logic      hit_cylinder,
  output hcount_t   hcount_out,
  output vcount_t   vcount_out
);

  typedef enum logic [1:0] {ST_IDLE, ST_TEST, ST_FINISH} state_t;

  localparam obj_idx_t SPHERE_IDX = obj_idx_t'(NUM_CYL);

  state_t   state;
  logic     busy;
  logic     accept;
  logic     any_sel;
  obj_idx_t first_sel;
  obj_idx_t last_sel;
  obj_idx_t cur_idx;
  obj_idx_t last_idx;
  obj_idx_t best_idx;
  depth_t   best_depth;
  logic     found;
  hcount_t  hcount_q;
  vcount_t  vcount_q;
  coord_t   ray_px;
  coord_t   ray_py;
  logic     test_is_cyl;
  logic     win_is_cyl;
  logic     isect_start;
  logic     isect_done;
  logic     isect_hit;
  depth_t   isect_depth;
  vec3_t    hp_pos;
  vec3_t    hp_normal;

  assign busy      = state != ST_IDLE;
  assign ray_ready = !busy;
  assign accept    = ray_valid && ray_ready;

  // Batch bounds, as a contiguous index range
  assign any_sel   = select_objs[SEL_SPHERE] || select_objs[SEL_CYL];
  assign first_sel = select_objs[SEL_CYL] ? '0 : SPHERE_IDX;
  assign last_sel  = select_objs[SEL_SPHERE] ? SPHERE_IDX : SPHERE_IDX - 1'b1;

  // Orthographic ray origin from the pixel position
  assign ray_px = coord_t'($signed({1'b0, hcount_q}) - SCREEN_W / 2);
  assign ray_py = coord_t'(SCREEN_H / 2 - $signed({1'b0, vcount_q}));

  assign test_idx    = cur_idx;
  assign win_idx     = best_idx;
  assign test_is_cyl = cur_idx != SPHERE_IDX;
  assign win_is_cyl  = best_idx != SPHERE_IDX;
  assign found       = best_depth != NO_HIT_DEPTH;

  always_ff @(posedge aclk) begin
    if (aresetn) begin
      state        <= ST_IDLE;
      isect_start  <= 1'b0;
      result_valid <= 1'b0;
      hit_sphere   <= 1'b0;
      hit_cylinder <= 1'b0;
      cur_idx      <= '0;
      last_idx     <= '0;
      best_idx     <= '0;
      best_depth   <= NO_HIT_DEPTH;
    end else begin
      isect_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            cur_idx     <= first_sel;
            last_idx    <= last_sel;
            best_idx    <= first_sel;
            best_depth  <= NO_HIT_DEPTH;
            isect_start <= any_sel;
            state       <= any_sel ? ST_TEST : ST_FINISH;   // Empty batch goes straight out
          end
        end
        ST_TEST: begin
          if (isect_done) begin
            if (isect_hit && isect_depth > best_depth) begin  // Strict, lower index keeps ties
              best_depth <= isect_depth;
              best_idx   <= cur_idx;
            end
            if (cur_idx == last_idx) begin
              state <= ST_FINISH;
            end else begin
              cur_idx     <= cur_idx + 1'b1;
              isect_start <= 1'b1;
            end
          end
        end
        ST_FINISH: begin
          if (!result_valid) begin
            result_valid <= 1'b1;
            hit_sphere   <= found && !win_is_cyl;
            hit_cylinder <= found && win_is_cyl;
          end else begin
            result_valid <= 1'b0;                      // Ready returns the cycle after the strobe
            state        <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      hcount_q <= ray_hcount;
      vcount_q <= ray_vcount;
    end
    if (state == ST_FINISH && !result_valid) begin
      hit_point  <= hp_pos;
      normal     <= hp_normal;
      hcount_out <= hcount_q;
      vcount_out <= vcount_q;
    end
  end

  ray_intersect i_ray_intersect (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .start       (isect_start),
    .px          (ray_px),
    .py          (ray_py),
    .obj         (test_obj),
    .is_cylinder (test_is_cyl),
    .done        (isect_done),
    .hit         (isect_hit),
    .depth       (isect_depth)
  );

  hit_point i_hit_point (
    .px          (ray_px),
    .py          (ray_py),
    .depth       (best_depth),
    .obj         (win_obj),
    .is_cylinder (win_is_cyl),
    .hit_pos     (hp_pos),
    .hit_normal  (hp_normal)
  );

endmodule

/* verilog/object_tracer_top.sv */
`timescale 1ns/1ps

module object_tracer_top
  import rt_geom_pkg::*, rt_trace_pkg::*;
#(
  parameter int NUM_CYL = 10
) (
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       obj_wr_en,
  input  obj_idx_t   obj_wr_idx,
  input  obj_desc_t  obj_wr_data,
  input  logic       ray_valid,
  output logic       ray_ready,
  input  hcount_t    ray_hcount,
  input  vcount_t    ray_vcount,
  input  logic [1:0] select_objs,
  output logic       result_valid,
  output vec3_t      hit_point,
  output vec3_t      normal,
  output logic       hit_sphere,
  output logic       hit_cylinder,
  output hcount_t    hcount_out,
  output vcount_t    vcount_out
);

  obj_idx_t  test_idx;
  obj_idx_t  win_idx;
  obj_desc_t test_obj;
  obj_desc_t win_obj;

  scene_store #(
    .NUM_CYL (NUM_CYL)
  ) i_scene_store (
    .aclk      (aclk),
    .wr_en     (obj_wr_en),
    .wr_idx    (obj_wr_idx),
    .wr_data   (obj_wr_data),
    .rd_idx_a  (test_idx),                             // Object under test
    .rd_idx_b  (win_idx),                              // Current nearest hit
    .rd_data_a (test_obj),
    .rd_data_b (win_obj)
  );

  check_objects #(
    .NUM_CYL (NUM_CYL)
  ) i_check_objects (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .ray_valid    (ray_valid),
    .ray_ready    (ray_ready),
    .ray_hcount   (ray_hcount),
    .ray_vcount   (ray_vcount),
    .select_objs  (select_objs),
    .test_idx     (test_idx),
    .win_idx      (win_idx),
    .test_obj     (test_obj),
    .win_obj      (win_obj),
    .result_valid (result_valid),
    .hit_point    (hit_point),
    .normal       (normal),
    .hit_sphere   (hit_sphere),
    .hit_cylinder (hit_cylinder),
    .hcount_out   (hcount_out),
    .vcount_out   (vcount_out)
  );

endmodule

/* verification/tb_object_tracer.sv */
`timescale 1ns/1ps

module tb_object_tracer
  import rt_geom_pkg::*, rt_trace_pkg::*;
;

  localparam int NUM_CYL = 10;
  localparam int CYCLES_PER_OBJ = 15;                  // Start, discriminant, 12 root steps, compare
  localparam int RESULT_TIMEOUT = (NUM_CYL + 1) * CYCLES_PER_OBJ + 40;
  localparam int READY_TIMEOUT = 100;

  logic       aclk = 1'b0;
  logic       aresetn;
  logic       obj_wr_en;
  obj_idx_t   obj_wr_idx;
  obj_desc_t  obj_wr_data;
  logic       ray_valid;
  logic       ray_ready;
  hcount_t    ray_hcount;
  vcount_t    ray_vcount;
  logic [1:0] select_objs;
  logic       result_valid;
  vec3_t      hit_point;
  vec3_t      normal;
  logic       hit_sphere;
  logic       hit_cylinder;
  hcount_t    hcount_out;
  vcount_t    vcount_out;

  obj_desc_t   scene_mem [NUM_CYL+1];                  // Model copy of the scene
  int unsigned rng_state = 32'd57474;
  int          err_count = 0;
  vec3_t       res_point;
  vec3_t       res_normal;
  logic        res_sph;
  logic        res_cyl;

  always #20 aclk = ~aclk;

  object_tracer_top #(
    .NUM_CYL (NUM_CYL)
  ) i_object_tracer_top (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .obj_wr_en    (obj_wr_en),
    .obj_wr_idx   (obj_wr_idx),
    .obj_wr_data  (obj_wr_data),
    .ray_valid    (ray_valid),
    .ray_ready    (ray_ready),
    .ray_hcount   (ray_hcount),
    .ray_vcount   (ray_vcount),
    .select_objs  (select_objs),
    .result_valid (result_valid),
    .hit_point    (hit_point),
    .normal       (normal),
    .hit_sphere   (hit_sphere),
    .hit_cylinder (hit_cylinder),
    .hcount_out   (hcount_out),
    .vcount_out   (vcount_out)
  );

  function automatic int unsigned next_rand();
    rng_state = rng_state ^ (rng_state << 13);         // xorshift32
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int unsigned span;
    span = hi - lo + 1;
    return lo + int'(next_rand() % span);
  endfunction

  function automatic int floor_root(input int d);
    int lo;
    int hi;
    int mid;
    lo = 0;
    hi = 4096;
    while (hi - lo > 1) begin                          // Largest lo with lo*lo <= d
      mid = (lo + hi) / 2;
      if (mid * mid <= d) lo = mid;
      else hi = mid;
    end
    return lo;
  endfunction

  function automatic obj_desc_t make_sph(input int cx, input int cy, input int cz, input int r);
    obj_desc_t d;
    d = '0;
    d.sph.cx = coord_t'(cx);
    d.sph.cy = coord_t'(cy);
    d.sph.cz = coord_t'(cz);
    d.sph.r  = coord_t'(r);
    return d;
  endfunction

  function automatic obj_desc_t make_cyl(input int cx, input int cz, input int r,
                                         input int y_lo, input int y_hi);
    obj_desc_t d;
    d = '0;
    d.cyl.cx   = coord_t'(cx);
    d.cyl.cz   = coord_t'(cz);
    d.cyl.r    = coord_t'(r);
    d.cyl.y_lo = coord_t'(y_lo);
    d.cyl.y_hi = coord_t'(y_hi);
    return d;
  endfunction

  function automatic vec3_t make_vec(input int x, input int y, input int z);
    vec3_t v;
    v.x = coord_t'(x);
    v.y = coord_t'(y);
    v.z = coord_t'(z);
    return v;
  endfunction

  // Reference model: nearest hit over the selected objects, lower index keeps ties
  function automatic void predict(input int px, input int py, input logic [1:0] sel,
                                  output logic found, output int win, output int best);
    int   i;
    int   d;
    int   dep;
    logic hit;
    found = 1'b0;
    win = 0;
    best = 0;
    for (i = 0; i <= NUM_CYL; i++) begin
      if (i == NUM_CYL) begin
        d = int'(scene_mem[i].sph.r) ** 2 - (px - int'(scene_mem[i].sph.cx)) ** 2
            - (py - int'(scene_mem[i].sph.cy)) ** 2;
        hit = sel[SEL_SPHERE] && d >= 0;
        dep = int'(scene_mem[i].sph.cz) + (d >= 0 ? floor_root(d) : 0);
      end else begin
        d = int'(scene_mem[i].cyl.r) ** 2 - (px - int'(scene_mem[i].cyl.cx)) ** 2;
        hit = sel[SEL_CYL] && d >= 0 && py >= int'(scene_mem[i].cyl.y_lo)
              && py <= int'(scene_mem[i].cyl.y_hi);
        dep = int'(scene_mem[i].cyl.cz) + (d >= 0 ? floor_root(d) : 0);
      end
      if (hit && (!found || dep > best)) begin
        found = 1'b1;
        win = i;
        best = dep;
      end
    end
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    $display("ERR %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_vec3(input vec3_t got, input vec3_t exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s is (%0d,%0d,%0d), expected (%0d,%0d,%0d)", what,
                             got.x, got.y, got.z, exp.x, exp.y, exp.z));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic compare_hcount(input hcount_t got, input hcount_t exp, input string what);
    if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic compare_vcount(input vcount_t got, input vcount_t exp, input string what);
    if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic write_obj(input int idx, input obj_desc_t data);
    @(posedge aclk);
    obj_wr_en   <= 1'b1;
    obj_wr_idx  <= obj_idx_t'(idx);
    obj_wr_data <= data;
    @(posedge aclk);
    obj_wr_en <= 1'b0;
    scene_mem[idx] = data;
  endtask

  // Nothing in a parked scene can be hit
  task automatic park_scene();
    for (int i = 0; i < NUM_CYL; i++) write_obj(i, make_cyl(0, 0, 1, 1, 0));
    write_obj(NUM_CYL, make_sph(1500, 0, 0, 1));
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (!ray_ready) begin
      cycles++;
      if (cycles > READY_TIMEOUT) report_timeout("ray_ready stayed low");
      @(negedge aclk);
    end
  endtask

  task automatic trace_and_check(input int h, input int v, input logic [1:0] sel);
    int   px;
    int   py;
    int   win;
    int   best;
    int   cycles;
    int   exp_lat;
    logic found;
    px = h - SCREEN_W / 2;
    py = SCREEN_H / 2 - v;
    exp_lat = ((sel[SEL_SPHERE] ? 1 : 0) + (sel[SEL_CYL] ? NUM_CYL : 0)) * CYCLES_PER_OBJ + 1;
    wait_ready();
    @(posedge aclk);
    ray_valid   <= 1'b1;
    ray_hcount  <= hcount_t'(h);
    ray_vcount  <= vcount_t'(v);
    select_objs <= sel;
    @(negedge aclk);
    compare_flag(ray_ready, 1'b1, "ray_ready before accept");
    @(posedge aclk);                                   // Ray accepted here
    ray_valid <= 1'b0;
    cycles = 0;
    @(negedge aclk);
    while (!result_valid) begin
      compare_flag(ray_ready, 1'b0, "ray_ready while a ray is in flight");
      cycles++;
      if (cycles > RESULT_TIMEOUT) report_timeout("result_valid never rose");
      @(negedge aclk);
    end
    if (cycles != exp_lat) begin
      report_error($sformatf("latency is %0d cycles, expected %0d", cycles, exp_lat));
    end
    compare_flag(ray_ready, 1'b0, "ray_ready with result_valid");
    res_point  = hit_point;
    res_normal = normal;
    res_sph    = hit_sphere;
    res_cyl    = hit_cylinder;
    predict(px, py, sel, found, win, best);
    compare_flag(hit_sphere, found && win == NUM_CYL, "hit_sphere");
    compare_flag(hit_cylinder, found && win != NUM_CYL, "hit_cylinder");
    compare_hcount(hcount_out, hcount_t'(h), "hcount_out");
    compare_vcount(vcount_out, vcount_t'(v), "vcount_out");
    if (found) begin
      compare_vec3(hit_point, make_vec(px, py, best), "hit_point");
      if (win == NUM_CYL) begin
        compare_vec3(normal, make_vec(px - int'(scene_mem[win].sph.cx),
                     py - int'(scene_mem[win].sph.cy), best - int'(scene_mem[win].sph.cz)),
                     "sphere normal");
      end else begin
        compare_vec3(normal, make_vec(px - int'(scene_mem[win].cyl.cx), 0,
                     best - int'(scene_mem[win].cyl.cz)), "cylinder normal");
      end
    end
    @(negedge aclk);
    compare_flag(result_valid, 1'b0, "result_valid after the strobe");
    compare_flag(ray_ready, 1'b1, "ray_ready after the strobe");
  endtask

  // Hand-worked expectations on top of the model
  task automatic check_directed(input logic sph, input logic cyl, input vec3_t pnt,
                                input vec3_t nrm);
    compare_flag(res_sph, sph, "directed hit_sphere");
    compare_flag(res_cyl, cyl, "directed hit_cylinder");
    if (sph || cyl) begin
      compare_vec3(res_point, pnt, "directed hit_point");
      compare_vec3(res_normal, nrm, "directed normal");
    end
  endtask

  task automatic test_empty_select();
    @(negedge aclk);
    compare_flag(ray_ready, 1'b1, "ray_ready after reset");
    compare_flag(result_valid, 1'b0, "result_valid after reset");
    trace_and_check(100, 200, 2'b00);
    check_directed(1'b0, 1'b0, '0, '0);
  endtask

  task automatic test_sphere();
    park_scene();
    write_obj(NUM_CYL, make_sph(0, 0, -100, 50));
    trace_and_check(512, 384, 2'b10);                  // Through the center
    check_directed(1'b1, 1'b0, make_vec(0, 0, -50), make_vec(0, 0, 50));
    trace_and_check(562, 384, 2'b10);                  // Grazing the rim
    check_directed(1'b1, 1'b0, make_vec(50, 0, -100), make_vec(50, 0, 0));
    trace_and_check(542, 344, 2'b10);
    check_directed(1'b1, 1'b0, make_vec(30, 40, -100), make_vec(30, 40, 0));
    trace_and_check(548, 348, 2'b10);                  // Just outside
    check_directed(1'b0, 1'b0, '0, '0);
    trace_and_check(522, 364, 2'b10);
  endtask

  task automatic test_cylinders();
    park_scene();
    write_obj(2, make_cyl(100, 0, 40, -50, 50));
    trace_and_check(612, 304, 2'b01);                  // Above the y range
    check_directed(1'b0, 1'b0, '0, '0);
    trace_and_check(612, 384, 2'b01);
    check_directed(1'b0, 1'b1, make_vec(100, 0, 40), make_vec(0, 0, 40));
    write_obj(3, make_cyl(110, 20, 40, -100, 100));
    trace_and_check(612, 384, 2'b01);                  // Index 3 sticks out further
    check_directed(1'b0, 1'b1, make_vec(100, 0, 58), make_vec(-10, 0, 38));
    write_obj(5, make_cyl(-200, 10, 30, -10, 10));
    write_obj(7, make_cyl(-200, 0, 40, -10, 10));
    trace_and_check(312, 384, 2'b01);                  // Equal depth, index 5 wins
    check_directed(1'b0, 1'b1, make_vec(-200, 0, 40), make_vec(0, 0, 30));
  endtask

  task automatic test_mixed();
    park_scene();
    write_obj(NUM_CYL, make_sph(0, 0, 0, 60));
    write_obj(4, make_cyl(0, 100, 20, -30, 30));
    trace_and_check(512, 384, 2'b11);
    check_directed(1'b0, 1'b1, make_vec(0, 0, 120), make_vec(0, 0, 20));
    trace_and_check(512, 384, 2'b10);
    check_directed(1'b1, 1'b0, make_vec(0, 0, 60), make_vec(0, 0, 60));
    write_obj(4, make_cyl(0, -100, 20, -30, 30));     // Now behind the sphere
    trace_and_check(512, 384, 2'b11);
    check_directed(1'b1, 1'b0, make_vec(0, 0, 60), make_vec(0, 0, 60));
  endtask

  task automatic test_random();
    int h;
    int v;
    int px;
    int py;
    int y_lo;
    for (int n = 0; n < 40; n++) begin
      h = rand_range(0, SCREEN_W - 1);
      v = rand_range(0, SCREEN_H - 1);
      px = h - SCREEN_W / 2;
      py = SCREEN_H / 2 - v;
      for (int i = 0; i < NUM_CYL; i++) begin
        y_lo = py + rand_range(-300, 100);
        write_obj(i, make_cyl(px + rand_range(-250, 250), rand_range(-800, 800),
                              rand_range(1, 300), y_lo, y_lo + rand_range(0, 400)));
      end
      write_obj(NUM_CYL, make_sph(px + rand_range(-250, 250), py + rand_range(-250, 250),
                                  rand_range(-800, 800), rand_range(1, 300)));
      trace_and_check(h, v, 2'(rand_range(0, 3)));
    end
  endtask

  initial begin
    aresetn     = 1'b1;
    obj_wr_en   = 1'b0;
    obj_wr_idx  = '0;
    obj_wr_data = '0;
    ray_valid   = 1'b0;
    ray_hcount  = '0;
    ray_vcount  = '0;
    select_objs = '0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b0;
    park_scene();
    test_empty_select();
    test_sphere();
    test_cylinders();
    test_mixed();
    test_random();
    if (err_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

/* project.f */
verilog/rt_geom_pkg.sv
verilog/rt_trace_pkg.sv
verilog/isqrt.sv
verilog/ray_intersect.sv
verilog/hit_point.sv
verilog/scene_store.sv
verilog/check_objects.sv
verilog/object_tracer_top.sv
verification/tb_object_tracer.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_object_tracer -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "Simulation ended without a verdict"
  exit 1
fi
echo "Simulation passed"
